//--- logic/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN = 32;

    // ALU operation codes.
    localparam int ALU_OP_WIDTH = 4;

    localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLT  = 4'd3;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_AND  = 4'd9;

    // Source of the value written back.
    localparam int RES_SRC_WIDTH = 2;

    localparam logic [RES_SRC_WIDTH-1:0] RES_ALU     = 2'd0;
    localparam logic [RES_SRC_WIDTH-1:0] RES_PC_NEXT = 2'd1;
    localparam logic [RES_SRC_WIDTH-1:0] RES_MEM     = 2'd2; // Address is the ALU value.

    // Operand select bits, all zero selects the register.
    localparam int OP1_SEL_PC    = 0;
    localparam int OP2_SEL_IMM_I = 0;
    localparam int OP2_SEL_IMM_J = 1;

    // One-hot forwarding select, all zero selects the register file.
    localparam int BP_WIDTH   = 4;
    localparam int BP_ALU2    = 0;
    localparam int BP_MEMORY  = 1;
    localparam int BP_WRITE   = 2;
    localparam int BP_WR_BACK = 3;

endpackage

`default_nettype wire

//--- logic/rv_bypass_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module rv_bypass_ctrl
(
    input  wire [4:0]                         i_rs1,
    input  wire [4:0]                         i_rs2,
    input  wire [4:0]                         i_alu2_rd,
    input  wire                               i_alu2_reg_write,
    input  wire [4:0]                         i_mem_rd,
    input  wire                               i_mem_reg_write,
    input  wire [4:0]                         i_wr_rd,
    input  wire                               i_wr_reg_write,
    input  wire [4:0]                         i_wb_rd,
    input  wire                               i_wb_reg_write,
    output logic [rv_exec_pkg::BP_WIDTH-1:0]  o_rs1_bp,
    output logic [rv_exec_pkg::BP_WIDTH-1:0]  o_rs2_bp
);

    // Youngest matching stage wins, x0 never forwards.
    function automatic logic [rv_exec_pkg::BP_WIDTH-1:0] bp_select(input logic [4:0] rs);
        logic [rv_exec_pkg::BP_WIDTH-1:0] sel;
        sel = '0;
        if (rs != 5'd0)
        begin
            if (i_alu2_reg_write && (i_alu2_rd == rs))
                sel[rv_exec_pkg::BP_ALU2] = 1'b1;
            else if (i_mem_reg_write && (i_mem_rd == rs))
                sel[rv_exec_pkg::BP_MEMORY] = 1'b1;
            else if (i_wr_reg_write && (i_wr_rd == rs))
                sel[rv_exec_pkg::BP_WRITE] = 1'b1;
            else if (i_wb_reg_write && (i_wb_rd == rs))
                sel[rv_exec_pkg::BP_WR_BACK] = 1'b1;
        end
        return sel;
    endfunction

    always_comb
    begin
        o_rs1_bp = bp_select(i_rs1);
        o_rs2_bp = bp_select(i_rs2);
    end

endmodule

`default_nettype wire

//--- logic/rv_alu1.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu1
(
    input  wire                                      i_clk,
    input  wire                                      i_reset,
    input  wire                                      i_stall,
    input  wire                                      i_flush,
    input  wire [rv_exec_pkg::BP_WIDTH-1:0]          i_rs1_bp,
    input  wire [rv_exec_pkg::BP_WIDTH-1:0]          i_rs2_bp,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_alu2_data,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_memory_data,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_write_data,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_wr_back_data,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_pc,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_pc_next,
    input  wire [4:0]                                i_rs1,
    input  wire [4:0]                                i_rs2,
    input  wire [4:0]                                i_rd,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_imm_i,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_imm_j,
    input  wire [rv_exec_pkg::ALU_OP_WIDTH-1:0]      i_alu_ctrl,
    input  wire [2:0]                                i_funct3,
    input  wire [rv_exec_pkg::RES_SRC_WIDTH-1:0]     i_res_src,
    input  wire                                      i_reg_write,
    input  wire                                      i_op1_src,
    input  wire [1:0]                                i_op2_src,
    input  wire                                      i_inst_jalr,
    input  wire                                      i_inst_jal,
    input  wire                                      i_inst_branch,
    input  wire                                      i_inst_store,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_reg1_data,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_reg2_data,
    output logic [rv_exec_pkg::XLEN-1:0]             o_op1,
    output logic [rv_exec_pkg::XLEN-1:0]             o_op2,
    output logic [rv_exec_pkg::ALU_OP_WIDTH-1:0]     o_ctrl,
    output logic                                     o_store,
    output logic                                     o_reg_write,
    output logic [4:0]                               o_rs1,
    output logic [4:0]                               o_rs2,
    output logic [4:0]                               o_rd,
    output logic                                     o_inst_jal_jalr,
    output logic                                     o_inst_branch,
    output logic [rv_exec_pkg::XLEN-1:0]             o_pc_next,
    output logic [rv_exec_pkg::XLEN-1:0]             o_pc_target,
    output logic [rv_exec_pkg::RES_SRC_WIDTH-1:0]    o_res_src,
    output logic [2:0]                               o_funct3,
    output logic [rv_exec_pkg::XLEN-1:0]             o_reg_data2
);

    logic                          inst_jal;
    logic                          inst_jalr;
    logic                          op1_sel;
    logic [1:0]                    op2_sel;
    logic [rv_exec_pkg::XLEN-1:0]  pc;
    logic [rv_exec_pkg::XLEN-1:0]  imm_i;
    logic [rv_exec_pkg::XLEN-1:0]  imm_j;
    logic [rv_exec_pkg::XLEN-1:0]  bp1;
    logic [rv_exec_pkg::XLEN-1:0]  bp2;

    // Control fields, cleared by reset or flush.
    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            o_rs1         <= '0;
            o_rs2         <= '0;
            o_rd          <= '0;
            o_reg_write   <= 1'b0;
            o_store       <= 1'b0;
            inst_jal      <= 1'b0;
            inst_jalr     <= 1'b0;
            o_inst_branch <= 1'b0;
        end
        else if (!i_stall)
        begin
            o_rs1         <= i_rs1;
            o_rs2         <= i_rs2;
            o_rd          <= i_rd;
            o_reg_write   <= i_reg_write;
            o_store       <= i_inst_store;
            inst_jal      <= i_inst_jal;
            inst_jalr     <= i_inst_jalr;
            o_inst_branch <= i_inst_branch;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
        begin
            pc        <= i_pc;
            o_pc_next <= i_pc_next;
            imm_i     <= i_imm_i;
            imm_j     <= i_imm_j;
            o_ctrl    <= i_alu_ctrl;
            o_funct3  <= i_funct3;
            o_res_src <= i_res_src;
            op1_sel   <= i_op1_src;
            op2_sel   <= i_op2_src;
        end
    end

    function automatic logic [rv_exec_pkg::XLEN-1:0] forward(
        input logic [rv_exec_pkg::BP_WIDTH-1:0] sel,
        input logic [rv_exec_pkg::XLEN-1:0]     reg_data
    );
        case (1'b1)
            sel[rv_exec_pkg::BP_ALU2]:    return i_alu2_data;
            sel[rv_exec_pkg::BP_MEMORY]:  return i_memory_data;
            sel[rv_exec_pkg::BP_WRITE]:   return i_write_data;
            sel[rv_exec_pkg::BP_WR_BACK]: return i_wr_back_data;
            default:                      return reg_data;
        endcase
    endfunction

    always_comb
    begin
        bp1 = forward(i_rs1_bp, i_reg1_data);
        bp2 = forward(i_rs2_bp, i_reg2_data);

        o_op1 = op1_sel ? pc : bp1;

        if (op2_sel[rv_exec_pkg::OP2_SEL_IMM_I])
            o_op2 = imm_i;
        else if (op2_sel[rv_exec_pkg::OP2_SEL_IMM_J])
            o_op2 = imm_j;
        else
            o_op2 = bp2;

        // Branch offsets also arrive in the J immediate.
        o_pc_target = inst_jalr ? (bp1 + imm_i) : (pc + imm_j);
    end

    assign o_inst_jal_jalr = inst_jal | inst_jalr;
    assign o_reg_data2     = bp2; // Store data.

endmodule

`default_nettype wire

//--- logic/rv_alu2.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu2
(
    input  wire                                      i_clk,
    input  wire                                      i_reset,
    input  wire                                      i_stall,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_op1,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_op2,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_reg_data2,
    input  wire [rv_exec_pkg::ALU_OP_WIDTH-1:0]      i_ctrl,
    input  wire [2:0]                                i_funct3,
    input  wire [rv_exec_pkg::RES_SRC_WIDTH-1:0]     i_res_src,
    input  wire [4:0]                                i_rd,
    input  wire                                      i_reg_write,
    input  wire                                      i_store,
    input  wire                                      i_inst_jal_jalr,
    input  wire                                      i_inst_branch,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_pc_next,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_pc_target,
    output logic [rv_exec_pkg::XLEN-1:0]             o_result,
    output logic [4:0]                               o_rd,
    output logic                                     o_reg_write,
    output logic                                     o_store,
    output logic [rv_exec_pkg::XLEN-1:0]             o_store_data,
    output logic [rv_exec_pkg::RES_SRC_WIDTH-1:0]    o_res_src,
    output logic                                     o_pc_change,
    output logic [rv_exec_pkg::XLEN-1:0]             o_pc_target
);

    logic [rv_exec_pkg::XLEN-1:0]          op1;
    logic [rv_exec_pkg::XLEN-1:0]          op2;
    logic [rv_exec_pkg::XLEN-1:0]          pc_next;
    logic [rv_exec_pkg::XLEN-1:0]          alu_out;
    logic [rv_exec_pkg::ALU_OP_WIDTH-1:0]  ctrl;
    logic [2:0]                            funct3;
    logic                                  jump;
    logic                                  branch;
    logic                                  taken;

    // A stall inserts a bubble here.
    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_stall)
        begin
            o_rd        <= '0;
            o_reg_write <= 1'b0;
            o_store     <= 1'b0;
            jump        <= 1'b0;
            branch      <= 1'b0;
        end
        else
        begin
            o_rd        <= i_rd;
            o_reg_write <= i_reg_write;
            o_store     <= i_store;
            jump        <= i_inst_jal_jalr;
            branch      <= i_inst_branch;
        end
    end

    always_ff @(posedge i_clk)
    begin
        op1          <= i_op1;
        op2          <= i_op2;
        ctrl         <= i_ctrl;
        funct3       <= i_funct3;
        pc_next      <= i_pc_next;
        o_pc_target  <= i_pc_target;
        o_store_data <= i_reg_data2;
        o_res_src    <= i_res_src;
    end

    always_comb
    begin
        case (ctrl)
            rv_exec_pkg::ALU_ADD:  alu_out = op1 + op2;
            rv_exec_pkg::ALU_SUB:  alu_out = op1 - op2;
            rv_exec_pkg::ALU_SLL:  alu_out = op1 << op2[4:0];
            rv_exec_pkg::ALU_SLT:  alu_out = {31'd0, $signed(op1) < $signed(op2)};
            rv_exec_pkg::ALU_SLTU: alu_out = {31'd0, op1 < op2};
            rv_exec_pkg::ALU_XOR:  alu_out = op1 ^ op2;
            rv_exec_pkg::ALU_SRL:  alu_out = op1 >> op2[4:0];
            rv_exec_pkg::ALU_SRA:  alu_out = $unsigned($signed(op1) >>> op2[4:0]);
            rv_exec_pkg::ALU_OR:   alu_out = op1 | op2;
            rv_exec_pkg::ALU_AND:  alu_out = op1 & op2;
            default:               alu_out = '0;
        endcase

        case (funct3)
            3'b000:  taken = (op1 == op2);
            3'b001:  taken = (op1 != op2);
            3'b100:  taken = ($signed(op1) < $signed(op2));
            3'b101:  taken = ($signed(op1) >= $signed(op2));
            3'b110:  taken = (op1 < op2);
            3'b111:  taken = (op1 >= op2);
            default: taken = 1'b0;
        endcase
    end

    // Loads and stores also take the ALU value as their address.
    assign o_result    = (o_res_src == rv_exec_pkg::RES_PC_NEXT) ? pc_next : alu_out;
    assign o_pc_change = jump | (branch & taken);

endmodule

`default_nettype wire

//--- logic/rv_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_top
(
    input  wire                                      i_clk,
    input  wire                                      i_reset,
    input  wire                                      i_stall,
    input  wire                                      i_flush,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_pc,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_pc_next,
    input  wire [4:0]                                i_rs1,
    input  wire [4:0]                                i_rs2,
    input  wire [4:0]                                i_rd,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_imm_i,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_imm_j,
    input  wire [rv_exec_pkg::ALU_OP_WIDTH-1:0]      i_alu_ctrl,
    input  wire [2:0]                                i_funct3,
    input  wire [rv_exec_pkg::RES_SRC_WIDTH-1:0]     i_res_src,
    input  wire                                      i_reg_write,
    input  wire                                      i_op1_src,
    input  wire [1:0]                                i_op2_src,
    input  wire                                      i_inst_jalr,
    input  wire                                      i_inst_jal,
    input  wire                                      i_inst_branch,
    input  wire                                      i_inst_store,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_reg1_data,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_reg2_data,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_memory_data,
    input  wire [4:0]                                i_mem_rd,
    input  wire                                      i_mem_reg_write,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_write_data,
    input  wire [4:0]                                i_wr_rd,
    input  wire                                      i_wr_reg_write,
    input  wire [rv_exec_pkg::XLEN-1:0]              i_wr_back_data,
    input  wire [4:0]                                i_wb_rd,
    input  wire                                      i_wb_reg_write,
    output wire [rv_exec_pkg::XLEN-1:0]              o_result,
    output wire [4:0]                                o_rd,
    output wire                                      o_reg_write,
    output wire                                      o_store,
    output wire [rv_exec_pkg::XLEN-1:0]              o_store_data,
    output wire [rv_exec_pkg::RES_SRC_WIDTH-1:0]     o_res_src,
    output wire                                      o_pc_change,
    output wire [rv_exec_pkg::XLEN-1:0]              o_pc_target
);

    logic [rv_exec_pkg::BP_WIDTH-1:0]       rs1_bp;
    logic [rv_exec_pkg::BP_WIDTH-1:0]       rs2_bp;
    logic [4:0]                             s1_rs1;
    logic [4:0]                             s1_rs2;
    logic [4:0]                             s1_rd;
    logic [rv_exec_pkg::XLEN-1:0]           s1_op1;
    logic [rv_exec_pkg::XLEN-1:0]           s1_op2;
    logic [rv_exec_pkg::XLEN-1:0]           s1_reg_data2;
    logic [rv_exec_pkg::XLEN-1:0]           s1_pc_next;
    logic [rv_exec_pkg::XLEN-1:0]           s1_pc_target;
    logic [rv_exec_pkg::ALU_OP_WIDTH-1:0]   s1_ctrl;
    logic [rv_exec_pkg::RES_SRC_WIDTH-1:0]  s1_res_src;
    logic [2:0]                             s1_funct3;
    logic                                   s1_store;
    logic                                   s1_reg_write;
    logic                                   s1_jal_jalr;
    logic                                   s1_branch;

    rv_bypass_ctrl u_bypass
    (
        .i_rs1(s1_rs1), .i_rs2(s1_rs2),
        .i_alu2_rd(o_rd), .i_alu2_reg_write(o_reg_write),
        .i_mem_rd(i_mem_rd), .i_mem_reg_write(i_mem_reg_write),
        .i_wr_rd(i_wr_rd), .i_wr_reg_write(i_wr_reg_write),
        .i_wb_rd(i_wb_rd), .i_wb_reg_write(i_wb_reg_write),
        .o_rs1_bp(rs1_bp), .o_rs2_bp(rs2_bp)
    );

    rv_alu1 u_alu1
    (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(i_stall), .i_flush(i_flush),
        .i_rs1_bp(rs1_bp), .i_rs2_bp(rs2_bp),
        .i_alu2_data(o_result), .i_memory_data(i_memory_data),
        .i_write_data(i_write_data), .i_wr_back_data(i_wr_back_data),
        .i_pc(i_pc), .i_pc_next(i_pc_next),
        .i_rs1(i_rs1), .i_rs2(i_rs2), .i_rd(i_rd),
        .i_imm_i(i_imm_i), .i_imm_j(i_imm_j),
        .i_alu_ctrl(i_alu_ctrl), .i_funct3(i_funct3), .i_res_src(i_res_src),
        .i_reg_write(i_reg_write), .i_op1_src(i_op1_src), .i_op2_src(i_op2_src),
        .i_inst_jalr(i_inst_jalr), .i_inst_jal(i_inst_jal),
        .i_inst_branch(i_inst_branch), .i_inst_store(i_inst_store),
        .i_reg1_data(i_reg1_data), .i_reg2_data(i_reg2_data),
        .o_op1(s1_op1), .o_op2(s1_op2), .o_ctrl(s1_ctrl),
        .o_store(s1_store), .o_reg_write(s1_reg_write),
        .o_rs1(s1_rs1), .o_rs2(s1_rs2), .o_rd(s1_rd),
        .o_inst_jal_jalr(s1_jal_jalr), .o_inst_branch(s1_branch),
        .o_pc_next(s1_pc_next), .o_pc_target(s1_pc_target),
        .o_res_src(s1_res_src), .o_funct3(s1_funct3), .o_reg_data2(s1_reg_data2)
    );

    rv_alu2 u_alu2
    (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(i_stall),
        .i_op1(s1_op1), .i_op2(s1_op2), .i_reg_data2(s1_reg_data2),
        .i_ctrl(s1_ctrl), .i_funct3(s1_funct3), .i_res_src(s1_res_src),
        .i_rd(s1_rd), .i_reg_write(s1_reg_write), .i_store(s1_store),
        .i_inst_jal_jalr(s1_jal_jalr), .i_inst_branch(s1_branch),
        .i_pc_next(s1_pc_next), .i_pc_target(s1_pc_target),
        .o_result(o_result), .o_rd(o_rd), .o_reg_write(o_reg_write),
        .o_store(o_store), .o_store_data(o_store_data), .o_res_src(o_res_src),
        .o_pc_change(o_pc_change), .o_pc_target(o_pc_target)
    );

endmodule

`default_nettype wire

//--- sim/tb_exec_model.svh
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

// Stage 1 shadow of the decoded fields.
logic [31:0] m1_pc, m1_pc_next, m1_imm_i, m1_imm_j;
logic [4:0]  m1_rs1, m1_rs2, m1_rd;
logic [3:0]  m1_ctrl;
logic [2:0]  m1_funct3;
logic [1:0]  m1_res_src, m1_op2_src;
logic        m1_op1_src, m1_reg_write, m1_store, m1_jal, m1_jalr, m1_branch, m1_valid;

// Stage 2 shadow holding the predicted DUT outputs.
logic [31:0] m2_result, m2_store_data, m2_pc_target;
logic [4:0]  m2_rd;
logic [1:0]  m2_res_src;
logic        m2_reg_write, m2_store, m2_pc_change, m2_chk;

function automatic logic [31:0] compute_alu(
    input logic [3:0]  op,
    input logic [31:0] a,
    input logic [31:0] b
);
    case (op)
        rv_exec_pkg::ALU_ADD:  return a + b;
        rv_exec_pkg::ALU_SUB:  return a + ~b + 32'd1;
        rv_exec_pkg::ALU_SLL:  return a << b[4:0];
        rv_exec_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        rv_exec_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        rv_exec_pkg::ALU_XOR:  return a ^ b;
        rv_exec_pkg::ALU_SRL:  return a >> b[4:0];
        rv_exec_pkg::ALU_SRA:  return (a >> b[4:0]) | (~(32'hffff_ffff >> b[4:0]) & {32{a[31]}});
        rv_exec_pkg::ALU_OR:   return a | b;
        rv_exec_pkg::ALU_AND:  return a & b;
        default:               return 32'd0;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a, b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return !($signed(a) < $signed(b));
        3'd6:    return a < b;
        3'd7:    return !(a < b);
        default: return 1'b0;
    endcase
endfunction

// Youngest writer wins in the order stage 2, memory, write and write-back.
function automatic logic [31:0] pick_forward(input logic [4:0] rs, input logic [31:0] reg_data);
    if (rs == 5'd0)
        return reg_data;
    if (m2_reg_write && (m2_rd == rs))
        return m2_result;
    if (i_mem_reg_write && (i_mem_rd == rs))
        return i_memory_data;
    if (i_wr_reg_write && (i_wr_rd == rs))
        return i_write_data;
    if (i_wb_reg_write && (i_wb_rd == rs))
        return i_wr_back_data;
    return reg_data;
endfunction

task automatic step_model();
    logic [31:0] fwd1, fwd2, op_a, op_b;
    logic        live;
    fwd1 = pick_forward(m1_rs1, i_reg1_data);
    fwd2 = pick_forward(m1_rs2, i_reg2_data);
    op_a = m1_op1_src ? m1_pc : fwd1;
    if (m1_op2_src[rv_exec_pkg::OP2_SEL_IMM_I])
        op_b = m1_imm_i;
    else if (m1_op2_src[rv_exec_pkg::OP2_SEL_IMM_J])
        op_b = m1_imm_j;
    else
        op_b = fwd2;

    live = m1_valid && !i_stall; // A stall sends a bubble.
    m2_chk        = live;
    m2_rd         = live ? m1_rd : 5'd0;
    m2_reg_write  = live && m1_reg_write;
    m2_store      = live && m1_store;
    m2_pc_change  = live && (m1_jal || m1_jalr ||
                             (m1_branch && branch_taken(m1_funct3, op_a, op_b)));
    m2_store_data = fwd2;
    m2_res_src    = m1_res_src;
    m2_pc_target  = m1_jalr ? (fwd1 + m1_imm_i) : (m1_pc + m1_imm_j);
    m2_result     = (m1_res_src == rv_exec_pkg::RES_PC_NEXT) ? m1_pc_next
                                                             : compute_alu(m1_ctrl, op_a, op_b);

    m1_valid = !i_flush && (i_stall ? m1_valid : 1'b1);
    if (!i_stall)
    begin
        {m1_pc, m1_pc_next, m1_imm_i, m1_imm_j, m1_rs1, m1_rs2, m1_rd} =
            {i_pc, i_pc_next, i_imm_i, i_imm_j, i_rs1, i_rs2, i_rd};
        {m1_ctrl, m1_funct3, m1_res_src, m1_op1_src, m1_op2_src} =
            {i_alu_ctrl, i_funct3, i_res_src, i_op1_src, i_op2_src};
        {m1_reg_write, m1_store, m1_jal, m1_jalr, m1_branch} =
            {i_reg_write, i_inst_store, i_inst_jal, i_inst_jalr, i_inst_branch};
    end
endtask

`endif

//--- sim/tb_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exec_top;

    localparam int NUM_CYCLES    = 3000;

    logic        i_clk, i_reset, i_stall, i_flush;
    logic [31:0] i_pc, i_pc_next, i_imm_i, i_imm_j, i_reg1_data, i_reg2_data;
    logic [31:0] i_memory_data, i_write_data, i_wr_back_data;
    logic [4:0]  i_rs1, i_rs2, i_rd, i_mem_rd, i_wr_rd, i_wb_rd;
    logic [3:0]  i_alu_ctrl;
    logic [2:0]  i_funct3;
    logic [1:0]  i_res_src, i_op2_src;
    logic        i_reg_write, i_op1_src, i_inst_jalr, i_inst_jal, i_inst_branch, i_inst_store;
    logic        i_mem_reg_write, i_wr_reg_write, i_wb_reg_write;
    logic [31:0] o_result, o_store_data, o_pc_target;
    logic [4:0]  o_rd;
    logic [1:0]  o_res_src;
    logic        o_reg_write, o_store, o_pc_change;

    rv_exec_top UUT (.*);

    `include "tb_exec_model.svh"

    initial
    begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic check_word(input logic [rv_exec_pkg::XLEN-1:0] got, exp, input string name);
        if (got !== exp)
            fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_rd(input logic [4:0] got, exp, input string name);
        if (got !== exp)
            fail_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    endtask

    task automatic check_bit(input logic got, exp, input string name);
        if (got !== exp)
            fail_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_res_src(input logic [rv_exec_pkg::RES_SRC_WIDTH-1:0] got, exp,
                                 input string name);
        if (got !== exp)
            fail_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    endtask

    // Small values and near-negative values make compares and branches interesting.
    function automatic logic [31:0] rand_word();
        case ($urandom_range(0, 3))
            0:       return $urandom_range(0, 3);
            1:       return 32'hffff_fff0 | $urandom_range(0, 15);
            default: return $urandom;
        endcase
    endfunction

    // Drives the decode fields for the next edge and the operand data for the stage 1 entry.
    task automatic drive_cycle();
        int          kind;
        logic [31:0] r;
        kind = $urandom_range(0, 7);
        r = $urandom;
        i_stall = ($urandom_range(0, 7) == 0);
        i_flush = ($urandom_range(0, 15) == 0);
        i_pc = $urandom & 32'h000f_fffc;
        i_pc_next = i_pc + 32'd4;
        i_rs1 = $urandom_range(0, 7); // Few registers make matches common.
        i_rs2 = $urandom_range(0, 7);
        i_rd = $urandom_range(0, 7);
        i_imm_i = {{20{r[11]}}, r[11:0]};
        i_imm_j = {{11{r[31]}}, r[31:12], 1'b0};
        i_alu_ctrl = $urandom_range(0, 9);
        i_funct3 = $urandom_range(0, 5);
        if (i_funct3 > 3'd1)
            i_funct3 = i_funct3 + 3'd2; // Skip the unused branch codes.
        i_res_src = rv_exec_pkg::RES_ALU;
        {i_reg_write, i_op1_src, i_op2_src} = 4'b1000;
        {i_inst_jal, i_inst_jalr, i_inst_branch, i_inst_store} = 4'b0000;
        case (kind)
            2: i_op2_src[rv_exec_pkg::OP2_SEL_IMM_I] = 1'b1;
            3:
            begin
                i_op1_src = 1'b1;
                i_op2_src[rv_exec_pkg::OP2_SEL_IMM_J] = 1'b1;
            end
            4: {i_inst_jal, i_res_src} = {1'b1, rv_exec_pkg::RES_PC_NEXT};
            5: {i_inst_jalr, i_res_src} = {1'b1, rv_exec_pkg::RES_PC_NEXT};
            6: {i_inst_branch, i_reg_write} = 2'b10;
            7:
            begin
                {i_inst_store, i_reg_write} = $urandom_range(1, 2); // Load or store.
                i_res_src = rv_exec_pkg::RES_MEM;
                i_op2_src[rv_exec_pkg::OP2_SEL_IMM_I] = 1'b1;
                i_alu_ctrl = rv_exec_pkg::ALU_ADD;
            end
            default: ;
        endcase
        i_reg1_data = rand_word();
        i_reg2_data = ($urandom_range(0, 3) == 0) ? i_reg1_data : rand_word();
        i_memory_data = rand_word();
        i_write_data = rand_word();
        i_wr_back_data = rand_word();
        i_mem_rd = $urandom_range(0, 7);
        i_wr_rd = $urandom_range(0, 7);
        i_wb_rd = $urandom_range(0, 7);
        {i_mem_reg_write, i_wr_reg_write, i_wb_reg_write} = $urandom_range(0, 7);
    endtask

    task automatic compare_outputs();
        check_bit(o_reg_write, m2_reg_write, "o_reg_write");
        check_bit(o_store, m2_store, "o_store");
        check_bit(o_pc_change, m2_pc_change, "o_pc_change");
        check_rd(o_rd, m2_rd, "o_rd");
        if (m2_chk)
        begin
            check_word(o_result, m2_result, "o_result");
            check_word(o_store_data, m2_store_data, "o_store_data");
            check_word(o_pc_target, m2_pc_target, "o_pc_target");
            check_res_src(o_res_src, m2_res_src, "o_res_src");
        end
    endtask

    initial
    begin
        void'($urandom(5253));
        i_reset = 1'b1;
        {i_stall, i_flush, i_pc, i_pc_next, i_imm_i, i_imm_j, i_reg1_data, i_reg2_data} = '0;
        {i_memory_data, i_write_data, i_wr_back_data, i_rs1, i_rs2, i_rd} = '0;
        {i_mem_rd, i_wr_rd, i_wb_rd, i_alu_ctrl, i_funct3, i_res_src, i_op2_src} = '0;
        {i_reg_write, i_op1_src, i_inst_jalr, i_inst_jal, i_inst_branch, i_inst_store} = '0;
        {i_mem_reg_write, i_wr_reg_write, i_wb_reg_write} = '0;
        // Active decode fields that reset has to keep out of both stages.
        {i_reg_write, i_inst_store, i_inst_jal, i_inst_branch} = 4'b1111;
        i_rd = 5'd7;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;

        check_bit(o_reg_write, 1'b0, "o_reg_write");
        check_bit(o_store, 1'b0, "o_store");
        check_bit(o_pc_change, 1'b0, "o_pc_change");
        check_rd(o_rd, 5'd0, "o_rd");
        {m1_valid, m2_chk, m2_reg_write, m2_store, m2_pc_change, m2_rd} = '0;

        for (int n = 0; n < NUM_CYCLES; n++)
        begin
            drive_cycle();
            step_model();
            @(negedge i_clk);
            compare_outputs();
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+sim
logic/rv_exec_pkg.sv
logic/rv_bypass_ctrl.sv
logic/rv_alu1.sv
logic/rv_alu2.sv
logic/rv_exec_top.sv
sim/tb_exec_top.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - logic/rv_exec_pkg.sv
  - logic/rv_bypass_ctrl.sv
  - logic/rv_alu1.sv
  - logic/rv_alu2.sv
  - logic/rv_exec_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_exec_top.sv
